// ==== frac_mem_32k.f ====
hdl/frac_mem_mode_pkg.sv
hdl/frac_mem_geom_pkg.sv
hdl/frac_mem_decode.sv
hdl/frac_mem_bank.sv
hdl/frac_mem_align.sv
hdl/frac_mem_32k.sv
test/frac_mem_32k_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module frac_mem_32k_tb -Mdir obj_dir -f frac_mem_32k.f \
    && ./obj_dir/Vfrac_mem_32k_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation finished: PASS" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }

// ==== test/frac_mem_32k_tb.sv ====
// Assumes a fixed two-cycle read latency and keeps rows below ROWS so every read hits a preloaded word
`timescale 1ns/1ps
`default_nettype none

module frac_mem_32k_tb;
    import frac_mem_mode_pkg::*;
    import frac_mem_geom_pkg::*;

    localparam int ROWS       = 8;
    localparam int NUM_RUNS   = 150;
    localparam int STEP_LIMIT = 40;

    logic              clk = 1'b0;
    logic              rst_n;
    mode_t             mode;
    mem_addr_u         addr_a;
    mem_addr_u         addr_b;
    logic [BANK_W-1:0] data_a;
    logic [BANK_W-1:0] data_b;
    logic              we_a;
    logic              we_b;
    logic [BANK_W-1:0] q_a;
    logic [BANK_W-1:0] q_b;

    // Reference memory, expected q and the two-entry result delay line
    logic [BANK_W-1:0] ref_mem [2][1 << ROW_W];
    logic [BANK_W-1:0] exp_q_a;
    logic [BANK_W-1:0] exp_q_b;
    logic              pend_rd_a [2];
    logic              pend_rd_b [2];
    logic [BANK_W-1:0] pend_q_a [2];
    logic [BANK_W-1:0] pend_q_b [2];
    logic [BANK_W-1:0] byte_word;
    int                check_count = 0;
    int                mismatch_count = 0;
    int                timeout_count = 0;

    frac_mem_32k u_frac_mem_32k (
        .clk(clk), .rst_n(rst_n), .mode(mode), .addr_a(addr_a), .addr_b(addr_b),
        .data_a(data_a), .data_b(data_b), .we_a(we_a), .we_b(we_b), .q_a(q_a), .q_b(q_b)
    );

    always #10 clk = ~clk;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Lane width in bits, 0 for reserved codes
    function automatic int lane_width(input mode_t m);
        case (m)
            SP64, SP32, DP32: return 32;
            SP16, DP16:       return 16;
            SP8, DP8:         return 8;
            SP4, DP4:         return 4;
            SP2, DP2:         return 2;
            SP1, DP1:         return 1;
            default:          return 0;
        endcase
    endfunction

    task automatic access(input logic bank, input logic [ROW_W-1:0] row,
                          input logic [LANE_W-1:0] lane, input int w, input logic we,
                          input logic [BANK_W-1:0] data, output logic [BANK_W-1:0] rval);
        logic [BANK_W-1:0] ones;
        int                off;
        ones = '0;
        for (int i = 0; i < w; i++) begin
            ones[i] = 1'b1;
        end
        // The lane number sits in the upper bits of the lane field
        off  = (int'(lane) / w) * w;
        rval = (ref_mem[bank][row] >> off) & ones;
        if (we) begin
            ref_mem[bank][row] = (ref_mem[bank][row] & ~(ones << off))
                               | ((data & ones) << off);
        end
    endtask

    // Apply the operation still on the inputs, which the last rising edge sampled
    task automatic model_step();
        int                w;
        logic              new_a;
        logic              new_b;
        logic [BANK_W-1:0] ra;
        logic [BANK_W-1:0] rb;
        if (pend_rd_a[1]) exp_q_a = pend_q_a[1];
        if (pend_rd_b[1]) exp_q_b = pend_q_b[1];
        pend_rd_a[1] = pend_rd_a[0];
        pend_rd_b[1] = pend_rd_b[0];
        pend_q_a[1]  = pend_q_a[0];
        pend_q_b[1]  = pend_q_b[0];
        new_a = 1'b0;
        new_b = 1'b0;
        ra    = '0;
        rb    = '0;
        w     = lane_width(mode);
        if (!rst_n) begin
            exp_q_a      = '0;
            exp_q_b      = '0;
            pend_rd_a[1] = 1'b0;
            pend_rd_b[1] = 1'b0;
        end else if (mode == SP64) begin
            // One row across both banks, upper half from port b
            access(1'b0, addr_a.dp.row, '0, w, we_a, data_a, ra);
            access(1'b1, addr_a.dp.row, '0, w, we_a, data_b, rb);
            new_a = !we_a;
            new_b = !we_a;
        end else if (mode inside {DP32, DP16, DP8, DP4, DP2, DP1}) begin
            access(1'b0, addr_a.dp.row, addr_a.dp.lane, w, we_a, data_a, ra);
            access(1'b1, addr_b.dp.row, addr_b.dp.lane, w, we_b, data_b, rb);
            new_a = !we_a;
            new_b = !we_b;
        end else if (w != 0) begin
            access(addr_a.sp.bank, addr_a.sp.row, addr_a.sp.lane, w, we_a, data_a, ra);
            new_a = !we_a;
        end
        pend_rd_a[0] = new_a;
        pend_rd_b[0] = new_b;
        pend_q_a[0]  = ra;
        pend_q_b[0]  = rb;
    endtask

    // ----------------------------------------
    // Checks, stimulus and cycle stepping
    // ----------------------------------------
    task automatic check_q_a(input logic [BANK_W-1:0] expected);
        check_count++;
        if (q_a !== expected) begin
            mismatch_count++;
            $display("mismatch at %0d ns: q_a is %h, expected %h", $time, q_a, expected);
        end
    endtask

    task automatic check_q_b(input logic [BANK_W-1:0] expected);
        check_count++;
        if (q_b !== expected) begin
            mismatch_count++;
            $display("mismatch at %0d ns: q_b is %h, expected %h", $time, q_b, expected);
        end
    endtask

    // Random data and addresses, rows limited to the preloaded range
    task automatic drive(input logic [3:0] code, input logic wa, input logic wb);
        mode   = mode_t'(code);
        we_a   = wa;
        we_b   = wb;
        data_a = $urandom;
        data_b = $urandom;
        addr_a = ADDR_W'($urandom);
        addr_b = ADDR_W'($urandom);
        addr_b.dp.row = ROW_W'($urandom % ROWS);
        if (mode inside {SP64, DP32, DP16, DP8, DP4, DP2, DP1}) begin
            addr_a.dp.row = ROW_W'($urandom % ROWS);
        end else begin
            addr_a.sp.row = ROW_W'($urandom % ROWS);
        end
    endtask

    // Move to the next falling edge, then update the model and compare q
    task automatic advance();
        int n;
        if (timeout_count != 0) return;
        n = 0;
        while (!clk && n < STEP_LIMIT) begin
            #1;
            n++;
        end
        while (clk && n < STEP_LIMIT) begin
            #1;
            n++;
        end
        if (n >= STEP_LIMIT) begin
            timeout_count++;
            $display("timeout: the clock did not complete a cycle within %0d ns", STEP_LIMIT);
            return;
        end
        model_step();
        check_q_a(exp_q_a);
        check_q_b(exp_q_b);
    endtask

    initial begin
        logic [3:0] code;
        int         len;
        void'($urandom(32'he0e4));
        rst_n = 1'b0;
        drive(4'd15, 1'b0, 1'b0);
        advance();
        advance();
        rst_n = 1'b1;

        // Preload the test rows of both banks, q must stay 0 meanwhile
        for (int b = 0; b < 2; b++) begin
            for (int r = 0; r < ROWS; r++) begin
                drive(4'(SP32), 1'b1, 1'b0);
                addr_a.sp.bank = 1'(b);
                addr_a.sp.row  = ROW_W'(r);
                advance();
            end
        end

        // Four byte writes read back as one word
        for (int k = 0; k < 4; k++) begin
            drive(4'(SP8), 1'b1, 1'b0);
            addr_a.sp.bank = 1'b0;
            addr_a.sp.row  = ROW_W'(2);
            addr_a.sp.lane = LANE_W'(k << 3);
            byte_word[8*k +: 8] = data_a[7:0];
            advance();
        end
        drive(4'(SP32), 1'b0, 1'b0);
        addr_a.sp.bank = 1'b0;
        addr_a.sp.row  = ROW_W'(2);
        advance();
        for (int k = 0; k < 2; k++) begin
            drive(4'd13 + 4'($urandom % 3), 1'($urandom), 1'($urandom));
            advance();
        end
        check_q_a(byte_word);

        // Random runs of one mode each, reserved codes included
        for (int run = 0; run < NUM_RUNS; run++) begin
            code = 4'($urandom);
            len  = 2 + int'($urandom % 12);
            for (int i = 0; i < len; i++) begin
                drive(code, 1'($urandom), 1'($urandom));
                advance();
            end
        end
        for (int k = 0; k < 3; k++) begin
            drive(4'd15, 1'b0, 1'b0);
            advance();
        end

        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/frac_mem_32k.sv ====
// Read latency is two cycles with one operation accepted per cycle and no byte enables or bypass
`timescale 1ns/1ps
`default_nettype none

module frac_mem_32k (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  frac_mem_mode_pkg::mode_t             mode,
    input  frac_mem_geom_pkg::mem_addr_u         addr_a,
    input  frac_mem_geom_pkg::mem_addr_u         addr_b,
    input  logic [frac_mem_geom_pkg::BANK_W-1:0] data_a,
    input  logic [frac_mem_geom_pkg::BANK_W-1:0] data_b,
    input  logic                                 we_a,
    input  logic                                 we_b,
    output logic [frac_mem_geom_pkg::BANK_W-1:0] q_a,
    output logic [frac_mem_geom_pkg::BANK_W-1:0] q_b
);
    import frac_mem_mode_pkg::*;
    import frac_mem_geom_pkg::*;

    // Decode to banks
    logic              bank0_en;
    logic              bank0_we;
    logic [ROW_W-1:0]  bank0_row;
    logic [BANK_W-1:0] bank0_wmask;
    logic [BANK_W-1:0] bank0_wdata;
    logic              bank1_en;
    logic              bank1_we;
    logic [ROW_W-1:0]  bank1_row;
    logic [BANK_W-1:0] bank1_wmask;
    logic [BANK_W-1:0] bank1_wdata;

    // Decode to align
    logic              rd_a;
    logic              src_a;
    logic [LANE_W-1:0] lane_a;
    width_code_t       width_a;
    logic              rd_b;
    logic [LANE_W-1:0] lane_b;
    width_code_t       width_b;

    // Banks to align
    logic [BANK_W-1:0] rdata0;
    logic [BANK_W-1:0] rdata1;

    // ----------------------------------------
    // Pipeline
    // ----------------------------------------
    frac_mem_decode u_decode (
        .clk(clk), .rst_n(rst_n), .mode(mode),
        .addr_a(addr_a), .addr_b(addr_b), .data_a(data_a), .data_b(data_b),
        .we_a(we_a), .we_b(we_b),
        .bank0_en(bank0_en), .bank0_we(bank0_we), .bank0_row(bank0_row),
        .bank0_wmask(bank0_wmask), .bank0_wdata(bank0_wdata),
        .bank1_en(bank1_en), .bank1_we(bank1_we), .bank1_row(bank1_row),
        .bank1_wmask(bank1_wmask), .bank1_wdata(bank1_wdata),
        .rd_a(rd_a), .src_a(src_a), .lane_a(lane_a), .width_a(width_a),
        .rd_b(rd_b), .lane_b(lane_b), .width_b(width_b)
    );

    frac_mem_bank u_bank0 (
        .clk(clk), .en(bank0_en), .we(bank0_we), .row(bank0_row),
        .wmask(bank0_wmask), .wdata(bank0_wdata), .rdata(rdata0)
    );

    frac_mem_bank u_bank1 (
        .clk(clk), .en(bank1_en), .we(bank1_we), .row(bank1_row),
        .wmask(bank1_wmask), .wdata(bank1_wdata), .rdata(rdata1)
    );

    frac_mem_align u_align (
        .clk(clk), .rst_n(rst_n),
        .rd_a(rd_a), .src_a(src_a), .lane_a(lane_a), .width_a(width_a),
        .rd_b(rd_b), .lane_b(lane_b), .width_b(width_b),
        .rdata0(rdata0), .rdata1(rdata1), .q_a(q_a), .q_b(q_b)
    );

endmodule

`default_nettype wire

// ==== hdl/frac_mem_align.sv ====
// Expects rdata one cycle after the routing inputs and leaves q unchanged on any cycle without a read
`timescale 1ns/1ps
`default_nettype none

module frac_mem_align (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 rd_a,
    input  logic                                 src_a,
    input  logic [frac_mem_geom_pkg::LANE_W-1:0] lane_a,
    input  frac_mem_mode_pkg::width_code_t       width_a,
    input  logic                                 rd_b,
    input  logic [frac_mem_geom_pkg::LANE_W-1:0] lane_b,
    input  frac_mem_mode_pkg::width_code_t       width_b,
    input  logic [frac_mem_geom_pkg::BANK_W-1:0] rdata0,
    input  logic [frac_mem_geom_pkg::BANK_W-1:0] rdata1,
    output logic [frac_mem_geom_pkg::BANK_W-1:0] q_a,
    output logic [frac_mem_geom_pkg::BANK_W-1:0] q_b
);
    import frac_mem_mode_pkg::*;
    import frac_mem_geom_pkg::*;

    logic              rd_a_q;
    logic              rd_b_q;
    logic              src_a_q;
    logic [LANE_W-1:0] lane_a_q;
    logic [LANE_W-1:0] lane_b_q;
    width_code_t       width_a_q;
    width_code_t       width_b_q;
    logic [BANK_W-1:0] word_a;

    // Shift the addressed lane down to bit 0 and clear everything above it
    function automatic logic [BANK_W-1:0] extract(input logic [BANK_W-1:0] word,
                                                  input logic [LANE_W-1:0] lane,
                                                  input width_code_t       w);
        logic [LANE_W-1:0] off;
        off = (lane >> w) << w;
        return (word >> off) & ({BANK_W{1'b1}} >> (BANK_W - (1 << w)));
    endfunction

    // ----------------------------------------
    // Routing delay to meet bank rdata
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_a_q <= 1'b0;
            rd_b_q <= 1'b0;
        end else begin
            rd_a_q <= rd_a;
            rd_b_q <= rd_b;
        end
    end

    always_ff @(posedge clk) begin
        src_a_q   <= src_a;
        lane_a_q  <= lane_a;
        width_a_q <= width_a;
        lane_b_q  <= lane_b;
        width_b_q <= width_b;
    end

    // Port b always reads bank 1
    assign word_a = src_a_q ? rdata1 : rdata0;

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_a <= '0;
            q_b <= '0;
        end else begin
            if (rd_a_q) begin
                q_a <= extract(word_a, lane_a_q, width_a_q);
            end
            if (rd_b_q) begin
                q_b <= extract(rdata1, lane_b_q, width_b_q);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/frac_mem_bank.sv ====
// Contents are undefined after reset and a read returns the old word when the row is written later
`timescale 1ns/1ps
`default_nettype none

module frac_mem_bank (
    input  logic                                 clk,
    input  logic                                 en,
    input  logic                                 we,
    input  logic [frac_mem_geom_pkg::ROW_W-1:0]  row,
    input  logic [frac_mem_geom_pkg::BANK_W-1:0] wmask,
    input  logic [frac_mem_geom_pkg::BANK_W-1:0] wdata,
    output logic [frac_mem_geom_pkg::BANK_W-1:0] rdata
);
    import frac_mem_geom_pkg::*;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    logic [BANK_W-1:0] mem [0:(1 << ROW_W)-1];

    // Only masked bits change on a write
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int i = 0; i < BANK_W; i++) begin
                if (wmask[i]) begin
                    mem[row][i] <= wdata[i];
                end
            end
        end
    end

    // Registered read, holds when idle or writing
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata <= mem[row];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/frac_mem_decode.sv ====
// Reserved modes produce no bank or read activity and port b is only active in dual modes and SP64
`timescale 1ns/1ps
`default_nettype none

module frac_mem_decode (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  frac_mem_mode_pkg::mode_t             mode,
    input  frac_mem_geom_pkg::mem_addr_u         addr_a,
    input  frac_mem_geom_pkg::mem_addr_u         addr_b,
    input  logic [frac_mem_geom_pkg::BANK_W-1:0] data_a,
    input  logic [frac_mem_geom_pkg::BANK_W-1:0] data_b,
    input  logic                                 we_a,
    input  logic                                 we_b,
    output logic                                 bank0_en,
    output logic                                 bank0_we,
    output logic [frac_mem_geom_pkg::ROW_W-1:0]  bank0_row,
    output logic [frac_mem_geom_pkg::BANK_W-1:0] bank0_wmask,
    output logic [frac_mem_geom_pkg::BANK_W-1:0] bank0_wdata,
    output logic                                 bank1_en,
    output logic                                 bank1_we,
    output logic [frac_mem_geom_pkg::ROW_W-1:0]  bank1_row,
    output logic [frac_mem_geom_pkg::BANK_W-1:0] bank1_wmask,
    output logic [frac_mem_geom_pkg::BANK_W-1:0] bank1_wdata,
    output logic                                 rd_a,
    output logic                                 src_a,
    output logic [frac_mem_geom_pkg::LANE_W-1:0] lane_a,
    output frac_mem_mode_pkg::width_code_t       width_a,
    output logic                                 rd_b,
    output logic [frac_mem_geom_pkg::LANE_W-1:0] lane_b,
    output frac_mem_mode_pkg::width_code_t       width_b
);
    import frac_mem_mode_pkg::*;
    import frac_mem_geom_pkg::*;

    logic              valid;
    logic              dual;
    logic              sp64;
    logic              a_hi;
    logic              b_act;
    logic              b_we;
    width_code_t       wc;
    logic [ROW_W-1:0]  row_a_c;
    logic [ROW_W-1:0]  row_b_c;
    logic [LANE_W-1:0] lane_a_c;
    logic [LANE_W-1:0] lane_b_c;

    // Field of ones, lane wide, placed at the lane's bit offset
    function automatic logic [BANK_W-1:0] lane_mask(input logic [LANE_W-1:0] lane,
                                                    input width_code_t       w);
        logic [LANE_W-1:0] off;
        off = (lane >> w) << w;
        return ({BANK_W{1'b1}} >> (BANK_W - (1 << w))) << off;
    endfunction

    // Low w bits of the data port repeated over the whole word
    function automatic logic [BANK_W-1:0] replicate(input logic [BANK_W-1:0] data,
                                                    input width_code_t       w);
        logic [BANK_W-1:0] word;
        for (int i = 0; i < BANK_W; i++) begin
            word[i] = data[LANE_W'(i) & LANE_W'((1 << w) - 1)];
        end
        return word;
    endfunction

    // ----------------------------------------
    // Address view and bank selection
    // ----------------------------------------
    always_comb begin
        valid = mode_is_valid(mode);
        dual  = mode_is_dual(mode);
        sp64  = (mode == SP64);
        wc    = mode_width(mode);

        if (dual || sp64) begin
            row_a_c  = addr_a.dp.row;
            lane_a_c = addr_a.dp.lane;
            a_hi     = 1'b0;
        end else begin
            row_a_c  = addr_a.sp.row;
            lane_a_c = addr_a.sp.lane;
            a_hi     = addr_a.sp.bank;
        end

        // In SP64 port b shadows port a's address and write enable
        b_act    = valid && (dual || sp64);
        row_b_c  = sp64 ? addr_a.dp.row : addr_b.dp.row;
        lane_b_c = sp64 ? addr_a.dp.lane : addr_b.dp.lane;
        b_we     = sp64 ? we_a : we_b;
    end

    // ----------------------------------------
    // Stage registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank0_en <= 1'b0;
            bank0_we <= 1'b0;
            bank1_en <= 1'b0;
            bank1_we <= 1'b0;
            rd_a     <= 1'b0;
            rd_b     <= 1'b0;
        end else begin
            bank0_en <= valid && !a_hi;
            bank0_we <= we_a;
            bank1_en <= (valid && a_hi) || b_act;
            bank1_we <= a_hi ? we_a : b_we;
            rd_a     <= valid && !we_a;
            rd_b     <= b_act && !b_we;
        end
    end

    always_ff @(posedge clk) begin
        bank0_row   <= row_a_c;
        bank0_wmask <= lane_mask(lane_a_c, wc);
        bank0_wdata <= replicate(data_a, wc);
        // Bank 1 takes port a for the upper half of single-port space
        if (a_hi) begin
            bank1_row   <= row_a_c;
            bank1_wmask <= lane_mask(lane_a_c, wc);
            bank1_wdata <= replicate(data_a, wc);
        end else begin
            bank1_row   <= row_b_c;
            bank1_wmask <= lane_mask(lane_b_c, wc);
            bank1_wdata <= replicate(data_b, wc);
        end
        src_a   <= a_hi;
        lane_a  <= lane_a_c;
        width_a <= wc;
        lane_b  <= lane_b_c;
        width_b <= wc;
    end

endmodule

`default_nettype wire

// ==== hdl/frac_mem_geom_pkg.sv ====
// Fixed geometry of two 512 x 32 banks behind a 15-bit address whose lane index is left-justified
`default_nettype none

package frac_mem_geom_pkg;

    // ----------------------------------------
    // Bank geometry
    // ----------------------------------------
    localparam int BANK_W = 32;
    localparam int ADDR_W = 15;
    localparam int LANE_W = 5;

    // Row bits are what is left after the bank bit and the lane index
    localparam int ROW_W  = ADDR_W - LANE_W - 1;

    // ----------------------------------------
    // Address views
    // ----------------------------------------
    // sp: single-port modes other than SP64, bank bit on top
    // dp: dual modes and SP64, low bit not used
    // A mode of width 2^k only looks at the top 5-k lane bits
    typedef union packed {
        struct packed {
            logic              bank;
            logic [ROW_W-1:0]  row;
            logic [LANE_W-1:0] lane;
        } sp;
        struct packed {
            logic [ROW_W-1:0]  row;
            logic [LANE_W-1:0] lane;
            logic              unused;
        } dp;
    } mem_addr_u;

endpackage

`default_nettype wire

// ==== hdl/frac_mem_mode_pkg.sv ====
// Codes 13 to 15 are reserved and rejected by mode_is_valid; lane widths are powers of two up to 32
`default_nettype none

package frac_mem_mode_pkg;

    // ----------------------------------------
    // Mode codes
    // ----------------------------------------
    typedef enum logic [3:0] {
        SP64 = 4'd0,
        SP32 = 4'd1,
        SP16 = 4'd2,
        SP8  = 4'd3,
        SP4  = 4'd4,
        SP2  = 4'd5,
        SP1  = 4'd6,
        DP32 = 4'd7,
        DP16 = 4'd8,
        DP8  = 4'd9,
        DP4  = 4'd10,
        DP2  = 4'd11,
        DP1  = 4'd12
    } mode_t;

    // Log2 of the lane width, 0 for 1 bit up to 5 for 32 bits
    typedef logic [2:0] width_code_t;

    // ----------------------------------------
    // Mode helpers
    // ----------------------------------------
    function automatic logic mode_is_valid(input mode_t m);
        return m <= DP1;
    endfunction

    function automatic logic mode_is_dual(input mode_t m);
        return (m >= DP32) && (m <= DP1);
    endfunction

    // SP64 counts as a full 32-bit word on each bank
    function automatic width_code_t mode_width(input mode_t m);
        case (m)
            SP16, DP16: return 3'd4;
            SP8,  DP8:  return 3'd3;
            SP4,  DP4:  return 3'd2;
            SP2,  DP2:  return 3'd1;
            SP1,  DP1:  return 3'd0;
            default:    return 3'd5;
        endcase
    endfunction

endpackage

`default_nettype wire
